// File: design/qa_params.svh
`ifndef QA_PARAMS_SVH
`define QA_PARAMS_SVH

// ====================
// Line and address geometry
// ====================

// One host cache line, written as a whole per memory strobe
`define QA_LINE_W 512
// Line address into host memory
`define QA_ADDR_W 32
// Line offset from the DSM base
`define QA_OFFSET_W 10
// Width of the progress counters in the test writer
`define QA_CNT_W 16

// Number of pattern lines written per test run
`define QA_TEST_LINES 8

// ====================
// Accelerator ID and pattern constants
// ====================

// The four low ID words, the upper twelve words are zero
`define QA_AFU_ID0 32'haced0000
`define QA_AFU_ID1 32'haced0001
`define QA_AFU_ID2 32'haced0002
`define QA_AFU_ID3 32'haced0003

// Upper half of every 32-bit word of a pattern line
`define QA_PATTERN_TAG 16'h5a5a

`endif

// File: design/qa_csr_pkg.sv
package qa_csr_pkg;

    // ====================
    // Host register map
    // ====================

    // Register addresses seen on csr_wr_addr
    typedef enum logic [3:0]
    {
        CSR_DSM_BASE      = 4'h0,
        CSR_ENABLE_TEST   = 4'h1,
        CSR_TRIGGER_DEBUG = 4'h2
    } t_csr_addr;

    // Write data carried with each host strobe
    typedef logic [31:0] t_csr_data;

    // The DSM base is written as a line address and fits one data word,
    // the trigger value is kept whole and reported back in the debug line

endpackage

// File: design/qa_ctrl_pkg.sv
`include "qa_params.svh"

package qa_ctrl_pkg;

    // ====================
    // Writer state types
    // ====================

    // Status writer states
    // INIT presents the accelerator ID, DEBUG presents the debug line
    typedef enum logic [1:0]
    {
        STATUS_INIT,
        STATUS_IDLE,
        STATUS_DEBUG
    } t_status_state;

    // Test writer states
    typedef enum logic
    {
        TEST_IDLE,
        TEST_RUN
    } t_test_state;

    // One full cache line of write data
    typedef logic [`QA_LINE_W-1:0] t_line;

endpackage

// File: design/qa_csr.sv
`timescale 1ns/1ps
`include "qa_params.svh"

module qa_csr
    import qa_csr_pkg::*;
(
    input  logic                  clk,
    input  logic                  resetb,

    // Host write strobe, one cycle, never stalled
    input  logic                  csr_wr_valid,
    input  t_csr_addr             csr_wr_addr,
    input  t_csr_data             csr_wr_data,

    output logic [`QA_ADDR_W-1:0] dsm_base,
    output logic                  dsm_base_valid,
    output logic                  enable_test,
    output logic                  trigger_debug,
    output t_csr_data             debug_req
);

    // ====================
    // Address decode
    // ====================

    logic wr_base;
    logic wr_enable;
    logic wr_trigger;

    assign wr_base    = csr_wr_valid && (csr_wr_addr == CSR_DSM_BASE);
    assign wr_enable  = csr_wr_valid && (csr_wr_addr == CSR_ENABLE_TEST);
    assign wr_trigger = csr_wr_valid && (csr_wr_addr == CSR_TRIGGER_DEBUG);

    // ====================
    // Registers
    // ====================

    // Control flags and command pulses
    // Every pulse lasts exactly one cycle, the cycle after the host write
    always_ff @(posedge clk)
    begin
        if (!resetb)
        begin
            dsm_base_valid <= 1'b0;
            enable_test    <= 1'b0;
            trigger_debug  <= 1'b0;
        end
        else
        begin
            // Sticky once any base has been written
            if (wr_base)
            begin
                dsm_base_valid <= 1'b1;
            end
            enable_test   <= wr_enable;
            trigger_debug <= wr_trigger;
        end
    end

    // Payload registers
    always_ff @(posedge clk)
    begin
        if (wr_base)
        begin
            dsm_base <= csr_wr_data;
        end
        // Trigger value travels alongside its pulse
        if (wr_trigger)
        begin
            debug_req <= csr_wr_data;
        end
    end

endmodule

// File: design/qa_status_writer.sv
`timescale 1ns/1ps
`include "qa_params.svh"

module qa_status_writer
    import qa_csr_pkg::*;
    import qa_ctrl_pkg::*;
(
    input  logic                   clk,
    input  logic                   resetb,

    input  logic                   dsm_base_valid,
    input  logic                   enable_test,
    input  logic                   trigger_debug,
    input  t_csr_data              debug_req,

    // Progress of the test writer, reported in the debug line
    input  logic [`QA_CNT_W-1:0]   lines_done,
    input  logic [`QA_CNT_W-1:0]   lines_left,

    input  logic                   status_grant,
    output logic                   status_req,
    output logic [`QA_OFFSET_W-1:0] status_offset,
    output t_line                  status_data
);

    t_status_state state;
    t_status_state next_state;

    // Trigger value held for the whole debug write
    t_csr_data debug_req_q;

    t_line id_line;
    t_line debug_line;

    // ====================
    // Line contents
    // ====================

    // ID line tells the host the accelerator is alive
    // Only the four low words carry the ID
    assign id_line = {{12{32'h0}}, `QA_AFU_ID3, `QA_AFU_ID2, `QA_AFU_ID1, `QA_AFU_ID0};

    // Debug line has the request in word 15 and test progress in words 1 and 0
    assign debug_line = {debug_req_q,
                         {13{32'h0}},
                         {{(32-`QA_CNT_W){1'b0}}, lines_left},
                         {{(32-`QA_CNT_W){1'b0}}, lines_done}};

    // ====================
    // FSM
    // ====================

    always_ff @(posedge clk)
    begin
        if (!resetb)
        begin
            state <= STATUS_INIT;
        end
        else
        begin
            state <= next_state;
        end
    end

    // Only one status write is outstanding at any time
    always_comb
    begin
        next_state = state;
        // A granted line is done, whatever else arrives with it
        if (status_grant)
        begin
            next_state = STATUS_IDLE;
        end
        // A new test is announced by writing the ID again
        else if (enable_test)
        begin
            next_state = STATUS_INIT;
        end
        else if (trigger_debug)
        begin
            next_state = STATUS_DEBUG;
        end
    end

    // Capture the value that came with the trigger pulse
    always_ff @(posedge clk)
    begin
        if (trigger_debug)
        begin
            debug_req_q <= debug_req;
        end
    end

    // ====================
    // Write request
    // ====================

    // Nothing may be written before the host has told us where DSM lives
    assign status_req = (state != STATUS_IDLE) && dsm_base_valid;

    // The status line is always DSM line 0
    assign status_offset = '0;

    assign status_data = (state == STATUS_DEBUG) ? debug_line : id_line;

endmodule

// File: design/qa_test_writer.sv
`timescale 1ns/1ps
`include "qa_params.svh"

module qa_test_writer
    import qa_ctrl_pkg::*;
(
    input  logic                    clk,
    input  logic                    resetb,

    input  logic                    dsm_base_valid,
    input  logic                    enable_test,

    input  logic                    test_grant,
    output logic                    test_req,
    output logic [`QA_OFFSET_W-1:0] test_offset,
    output t_line                   test_data,

    output logic [`QA_CNT_W-1:0]    lines_done,
    output logic [`QA_CNT_W-1:0]    lines_left
);

    t_test_state state;

    // Number of the line currently offered, counting from 1
    logic [`QA_CNT_W-1:0] line_num;
    logic [31:0]          pattern_word;

    // ====================
    // Run control and counters
    // ====================

    // An enable always restarts the run from line 1
    // Each grant retires one line, the last grant ends the run
    always_ff @(posedge clk)
    begin
        if (!resetb)
        begin
            state      <= TEST_IDLE;
            lines_done <= '0;
            lines_left <= '0;
        end
        else if (enable_test)
        begin
            state      <= TEST_RUN;
            lines_done <= '0;
            lines_left <= `QA_CNT_W'(`QA_TEST_LINES);
        end
        else if (test_grant)
        begin
            lines_done <= lines_done + 1'b1;
            lines_left <= lines_left - 1'b1;
            if (lines_left == `QA_CNT_W'(1))
            begin
                state <= TEST_IDLE;
            end
        end
    end

    // ====================
    // Line generation
    // ====================

    assign line_num = lines_done + 1'b1;

    // Request every cycle of the run, the arbiter decides when we go
    assign test_req = (state == TEST_RUN) && dsm_base_valid;

    // Line k lands at DSM line k, line 0 belongs to the status writer
    assign test_offset = line_num[`QA_OFFSET_W-1:0];

    // Every word tags the line number so the host can spot misplaced lines
    assign pattern_word = {`QA_PATTERN_TAG, line_num};
    assign test_data    = {(`QA_LINE_W/32){pattern_word}};

endmodule

// File: design/qa_write_arb.sv
`timescale 1ns/1ps
`include "qa_params.svh"

module qa_write_arb
    import qa_ctrl_pkg::*;
(
    input  logic                    clk,
    input  logic                    resetb,

    input  logic                    status_req,
    input  logic [`QA_OFFSET_W-1:0] status_offset,
    input  t_line                   status_data,
    input  logic                    test_req,
    input  logic [`QA_OFFSET_W-1:0] test_offset,
    input  t_line                   test_data,
    input  logic [`QA_ADDR_W-1:0]   dsm_base,

    output logic                    status_grant,
    output logic                    test_grant,

    output logic                    mem_wr_valid,
    output logic [`QA_ADDR_W-1:0]   mem_wr_addr,
    output t_line                   mem_wr_data
);

    logic [`QA_OFFSET_W-1:0] win_offset;
    t_line                   win_data;

    // ====================
    // Fixed priority grant
    // ====================

    // Status writer always wins, the test writer takes what is left
    assign status_grant = status_req;
    assign test_grant   = test_req && !status_req;

    assign win_offset = status_grant ? status_offset : test_offset;
    assign win_data   = status_grant ? status_data : test_data;

    // ====================
    // Registered memory port
    // ====================

    always_ff @(posedge clk)
    begin
        if (!resetb)
        begin
            mem_wr_valid <= 1'b0;
        end
        else
        begin
            mem_wr_valid <= status_grant || test_grant;
        end
    end

    // Address and data only matter while mem_wr_valid is high
    always_ff @(posedge clk)
    begin
        mem_wr_addr <= dsm_base + `QA_ADDR_W'(win_offset);
        mem_wr_data <= win_data;
    end

endmodule

// File: design/qa_driver_top.sv
`timescale 1ns/1ps
`include "qa_params.svh"

module qa_driver_top
    import qa_csr_pkg::*;
    import qa_ctrl_pkg::*;
(
    input  logic                  clk,
    input  logic                  resetb,

    input  logic                  csr_wr_valid,
    input  t_csr_addr             csr_wr_addr,
    input  t_csr_data             csr_wr_data,

    output logic                  mem_wr_valid,
    output logic [`QA_ADDR_W-1:0] mem_wr_addr,
    output t_line                 mem_wr_data
);

    // ====================
    // Internal wiring
    // ====================

    // Register block outputs
    logic [`QA_ADDR_W-1:0]   dsm_base;
    logic                    dsm_base_valid;
    logic                    enable_test;
    logic                    trigger_debug;
    t_csr_data               debug_req;

    // Writer requests towards the arbiter
    logic                    status_req;
    logic [`QA_OFFSET_W-1:0] status_offset;
    t_line                   status_data;
    logic                    test_req;
    logic [`QA_OFFSET_W-1:0] test_offset;
    t_line                   test_data;

    // Grants and test progress
    logic                    status_grant;
    logic                    test_grant;
    logic [`QA_CNT_W-1:0]    lines_done;
    logic [`QA_CNT_W-1:0]    lines_left;

    // ====================
    // Blocks
    // ====================

    qa_csr qa_csr_inst
    (
        .clk            (clk),
        .resetb         (resetb),
        .csr_wr_valid   (csr_wr_valid),
        .csr_wr_addr    (csr_wr_addr),
        .csr_wr_data    (csr_wr_data),
        .dsm_base       (dsm_base),
        .dsm_base_valid (dsm_base_valid),
        .enable_test    (enable_test),
        .trigger_debug  (trigger_debug),
        .debug_req      (debug_req)
    );

    // Owns DSM line 0
    qa_status_writer qa_status_writer_inst
    (
        .clk            (clk),
        .resetb         (resetb),
        .dsm_base_valid (dsm_base_valid),
        .enable_test    (enable_test),
        .trigger_debug  (trigger_debug),
        .debug_req      (debug_req),
        .lines_done     (lines_done),
        .lines_left     (lines_left),
        .status_grant   (status_grant),
        .status_req     (status_req),
        .status_offset  (status_offset),
        .status_data    (status_data)
    );

    // Streams the pattern lines to DSM lines 1 and up
    qa_test_writer qa_test_writer_inst
    (
        .clk            (clk),
        .resetb         (resetb),
        .dsm_base_valid (dsm_base_valid),
        .enable_test    (enable_test),
        .test_grant     (test_grant),
        .test_req       (test_req),
        .test_offset    (test_offset),
        .test_data      (test_data),
        .lines_done     (lines_done),
        .lines_left     (lines_left)
    );

    qa_write_arb qa_write_arb_inst
    (
        .clk            (clk),
        .resetb         (resetb),
        .status_req     (status_req),
        .status_offset  (status_offset),
        .status_data    (status_data),
        .test_req       (test_req),
        .test_offset    (test_offset),
        .test_data      (test_data),
        .dsm_base       (dsm_base),
        .status_grant   (status_grant),
        .test_grant     (test_grant),
        .mem_wr_valid   (mem_wr_valid),
        .mem_wr_addr    (mem_wr_addr),
        .mem_wr_data    (mem_wr_data)
    );

endmodule

// File: test/qa_driver_sva.sv
`timescale 1ns/1ps

module qa_driver_sva
(
    input logic clk,
    input logic resetb,
    input logic status_grant,
    input logic test_grant,
    input logic dsm_base_valid,
    input logic mem_wr_valid
);

    // Failures seen so far, read by the testbench at the end of the run
    int assert_errors = 0;

    // ====================
    // Arbiter and port rules
    // ====================

    // Fixed priority means at most one writer owns the port per cycle
    grant_exclusive: assert property (@(posedge clk) disable iff (!resetb)
        !(status_grant && test_grant))
    else
    begin
        assert_errors++;
        $error("Status and test writer granted in the same cycle");
    end

    // A strobe was granted one cycle earlier, so the base had to be valid then
    write_after_base: assert property (@(posedge clk) disable iff (!resetb)
        mem_wr_valid |-> $past(dsm_base_valid))
    else
    begin
        assert_errors++;
        $error("Memory write issued before the DSM base was valid");
    end

    // The registered port comes out of reset idle
    quiet_after_reset: assert property (@(posedge clk) $rose(resetb) |-> !mem_wr_valid)
    else
    begin
        assert_errors++;
        $error("Memory write strobe high in the first cycle after reset");
    end

endmodule

// File: test/qa_driver_checker.sv
`timescale 1ns/1ps
`include "qa_params.svh"

module qa_driver_checker
    import qa_csr_pkg::*;
    import qa_ctrl_pkg::*;
(
    input  logic                  clk,
    input  logic                  resetb,
    input  logic                  csr_wr_valid,
    input  t_csr_addr             csr_wr_addr,
    input  t_csr_data             csr_wr_data,
    input  logic                  mem_wr_valid,
    input  logic [`QA_ADDR_W-1:0] mem_wr_addr,
    input  t_line                 mem_wr_data,
    output int                    error_count,
    output int                    check_count
);

    // What the status writer still owes on DSM line 0
    localparam int PEND_NONE  = 0;
    localparam int PEND_ID    = 1;
    localparam int PEND_DEBUG = 2;

    int                    cycle;
    bit                    base_seen;
    logic [`QA_ADDR_W-1:0] exp_base;
    int                    pend;
    int                    pend_cycle;
    t_csr_data             trig_value;
    bit                    run_loaded;
    bit                    run_active;
    int                    next_line;
    int                    patterns_seen;

    initial
    begin
        error_count = 0;
        check_count = 0;
        cycle       = 0;
    end

    // ====================
    // Expected line contents
    // ====================

    function automatic t_line id_line_model();
        t_line l;
        l          = '0;
        l[31:0]    = `QA_AFU_ID0;
        l[63:32]   = `QA_AFU_ID1;
        l[95:64]   = `QA_AFU_ID2;
        l[127:96]  = `QA_AFU_ID3;
        return l;
    endfunction

    // Every word carries the tag and the line number
    function automatic t_line pattern_line_model(input int k);
        t_line l;
        int    w;
        for (w = 0; w < `QA_LINE_W / 32; w++)
        begin
            l[w*32 +: 32] = {`QA_PATTERN_TAG, k[15:0]};
        end
        return l;
    endfunction

    function automatic t_line debug_line_model(input t_csr_data v, input int done, input int left);
        t_line l;
        l                        = '0;
        l[`QA_LINE_W-1 -: 32]    = v;
        l[63:32]                 = left;
        l[31:0]                  = done;
        return l;
    endfunction

    // ====================
    // Reporting and comparing
    // ====================

    task automatic report_error(input string msg);
        error_count++;
        $display("[ERROR] %0t: %s", $time, msg);
    endtask

    // Reports the first word that differs
    task automatic compare_line(input t_line got, input t_line exp, input string what,
                                input logic [`QA_ADDR_W-1:0] addr);
        int w;
        int first;
        first = -1;
        for (w = 0; w < `QA_LINE_W / 32; w++)
        begin
            if (got[w*32 +: 32] !== exp[w*32 +: 32] && first < 0)
            begin
                first = w;
            end
        end
        if (first >= 0)
        begin
            report_error($sformatf("%s at 0x%h word %0d is %h, expected %h", what, addr,
                                   first, got[first*32 +: 32], exp[first*32 +: 32]));
        end
    endtask

    task automatic check_write();
        int left;
        check_count++;
        if (!base_seen)
        begin
            report_error($sformatf("write to 0x%h before any DSM base", mem_wr_addr));
        end
        else if (mem_wr_addr == exp_base)
        begin
            if (pend == PEND_NONE)
            begin
                report_error("write to DSM line 0 with no status update due");
            end
            else
            begin
                if (cycle != pend_cycle)
                begin
                    report_error($sformatf("status line at cycle %0d, expected cycle %0d",
                                           cycle, pend_cycle));
                end
                if (pend == PEND_ID)
                begin
                    compare_line(mem_wr_data, id_line_model(), "ID line", mem_wr_addr);
                end
                else
                begin
                    left = run_loaded ? `QA_TEST_LINES - patterns_seen : 0;
                    compare_line(mem_wr_data, debug_line_model(trig_value, patterns_seen, left),
                                 "debug line", mem_wr_addr);
                end
                pend = PEND_NONE;
            end
        end
        else if (!run_active)
        begin
            report_error($sformatf("pattern write to 0x%h with no test run", mem_wr_addr));
        end
        else
        begin
            if (mem_wr_addr != exp_base + 32'(next_line))
            begin
                report_error($sformatf("pattern line %0d at 0x%h, expected 0x%h", next_line,
                                       mem_wr_addr, exp_base + 32'(next_line)));
            end
            compare_line(mem_wr_data, pattern_line_model(next_line), "pattern line",
                         mem_wr_addr);
            next_line++;
            patterns_seen++;
            if (next_line > `QA_TEST_LINES)
            begin
                run_active = 1'b0;
            end
        end
    endtask

    // ====================
    // Host command model
    // ====================

    // The first base write releases the pending ID one cycle sooner than a command pulse
    task automatic snoop_csr();
        case (csr_wr_addr)
            CSR_DSM_BASE:
            begin
                if (!base_seen && pend == PEND_ID)
                begin
                    pend_cycle = cycle + 2;
                end
                base_seen = 1'b1;
                exp_base  = csr_wr_data;
            end
            CSR_ENABLE_TEST:
            begin
                pend          = PEND_ID;
                pend_cycle    = cycle + 3;
                run_loaded    = 1'b1;
                run_active    = 1'b1;
                next_line     = 1;
                patterns_seen = 0;
            end
            CSR_TRIGGER_DEBUG:
            begin
                pend       = PEND_DEBUG;
                pend_cycle = cycle + 3;
                trig_value = csr_wr_data;
            end
            default:
            begin
            end
        endcase
    endtask

    always @(posedge clk)
    begin
        cycle = cycle + 1;
        if (!resetb)
        begin
            // Reset forgets the base and leaves the ID line owed
            base_seen     = 1'b0;
            pend          = PEND_ID;
            pend_cycle    = -1;
            run_loaded    = 1'b0;
            run_active    = 1'b0;
            next_line     = 1;
            patterns_seen = 0;
        end
        else
        begin
            if (mem_wr_valid)
            begin
                check_write();
            end
            // A status line that is past its cycle and still owed was never written
            if (pend != PEND_NONE && pend_cycle >= 0 && cycle > pend_cycle)
            begin
                report_error($sformatf("status line due at cycle %0d was never written",
                                       pend_cycle));
                pend = PEND_NONE;
            end
            if (csr_wr_valid)
            begin
                snoop_csr();
            end
        end
    end

endmodule

// File: test/qa_driver_tb.sv
`timescale 1ns/1ps
`include "qa_params.svh"

module qa_driver_tb
    import qa_csr_pkg::*;
    import qa_ctrl_pkg::*;
();

    localparam int STEP_CSR   = 0;
    localparam int STEP_WAIT  = 1;
    localparam int STEP_RESET = 2;
    localparam int WAIT_LIMIT = 64;

    // One table row: what to do, then which write ends it, then idle cycles
    typedef struct packed
    {
        logic [1:0] kind;
        t_csr_addr  addr;
        t_csr_data  data;
        int         wait_off;
        int         idle;
    } t_step;

    logic                  clk;
    logic                  resetb;
    logic                  csr_wr_valid;
    t_csr_addr             csr_wr_addr;
    t_csr_data             csr_wr_data;
    logic                  mem_wr_valid;
    logic [`QA_ADDR_W-1:0] mem_wr_addr;
    t_line                 mem_wr_data;

    int                    error_count;
    int                    check_count;
    int                    sva_fails;
    int                    timeouts;
    int                    i;
    integer                seed;
    logic [`QA_ADDR_W-1:0] cur_base;
    t_step                 steps[$];

    qa_driver_top qa_driver_top_inst
    (
        .clk          (clk),
        .resetb       (resetb),
        .csr_wr_valid (csr_wr_valid),
        .csr_wr_addr  (csr_wr_addr),
        .csr_wr_data  (csr_wr_data),
        .mem_wr_valid (mem_wr_valid),
        .mem_wr_addr  (mem_wr_addr),
        .mem_wr_data  (mem_wr_data)
    );

    qa_driver_checker qa_driver_checker_inst
    (
        .clk          (clk),
        .resetb       (resetb),
        .csr_wr_valid (csr_wr_valid),
        .csr_wr_addr  (csr_wr_addr),
        .csr_wr_data  (csr_wr_data),
        .mem_wr_valid (mem_wr_valid),
        .mem_wr_addr  (mem_wr_addr),
        .mem_wr_data  (mem_wr_data),
        .error_count  (error_count),
        .check_count  (check_count)
    );

    // Grant signals are internal, so the assertions sit inside the DUT top
    bind qa_driver_top qa_driver_sva qa_driver_sva_inst
    (
        .clk            (clk),
        .resetb         (resetb),
        .status_grant   (status_grant),
        .test_grant     (test_grant),
        .dsm_base_valid (dsm_base_valid),
        .mem_wr_valid   (mem_wr_valid)
    );

    initial
    begin
        clk = 1'b0;
    end

    always #2 clk = ~clk;

    // ====================
    // Stimulus helpers
    // ====================

    task automatic add_step(input int kind, input t_csr_addr addr, input t_csr_data data,
                            input int wait_off, input int idle);
        steps.push_back({kind[1:0], addr, data, wait_off, idle});
    endtask

    // One-cycle host strobe, launched and removed on falling edges
    task automatic write_csr(input t_csr_addr addr, input t_csr_data data);
        csr_wr_valid = 1'b1;
        csr_wr_addr  = addr;
        csr_wr_data  = data;
        @(negedge clk);
        csr_wr_valid = 1'b0;
    endtask

    task automatic apply_reset();
        resetb = 1'b0;
        repeat (3) @(negedge clk);
        resetb = 1'b1;
    endtask

    // Watches the memory port for a line at the current base plus the offset
    task automatic wait_for_write(input int offset);
        int  n;
        bit  found;
        found = 1'b0;
        for (n = 0; n < WAIT_LIMIT && !found; n++)
        begin
            @(negedge clk);
            if (mem_wr_valid && mem_wr_addr == cur_base + 32'(offset))
            begin
                found = 1'b1;
            end
        end
        if (!found)
        begin
            timeouts++;
            $display("Timeout at %0t: no memory write to offset %0d within %0d cycles",
                     $time, offset, WAIT_LIMIT);
        end
    endtask

    task automatic run_step(input t_step s);
        if (s.kind == STEP_CSR)
        begin
            if (s.addr == CSR_DSM_BASE)
            begin
                cur_base = s.data;
            end
            write_csr(s.addr, s.data);
        end
        else if (s.kind == STEP_RESET)
        begin
            apply_reset();
        end
        if (s.wait_off >= 0)
        begin
            wait_for_write(s.wait_off);
        end
        repeat (s.idle) @(negedge clk);
    endtask

    // ====================
    // Stimulus table
    // ====================

    task automatic build_table();
        // Nothing may be written before a base exists
        add_step(STEP_WAIT, CSR_DSM_BASE, 32'h0, -1, 10);
        add_step(STEP_CSR, CSR_DSM_BASE, 32'h0000_1000, 0, 4);
        // Full run with its leading ID line
        add_step(STEP_CSR, CSR_ENABLE_TEST, 32'h1, `QA_TEST_LINES, 4);
        // Debug while the pattern stream is running
        add_step(STEP_CSR, CSR_ENABLE_TEST, 32'h1, 2, 0);
        add_step(STEP_CSR, CSR_TRIGGER_DEBUG, t_csr_data'($random(seed)), 0, 0);
        add_step(STEP_WAIT, CSR_DSM_BASE, 32'h0, `QA_TEST_LINES, 4);
        // Debug once the run has finished
        add_step(STEP_CSR, CSR_TRIGGER_DEBUG, t_csr_data'($random(seed)), 0, 4);
        // Move the base and run again there
        add_step(STEP_CSR, CSR_DSM_BASE, 32'h0000_2400, -1, 4);
        add_step(STEP_CSR, CSR_ENABLE_TEST, 32'h1, `QA_TEST_LINES, 4);
        // Reset cuts a run short, then a fresh base and run
        add_step(STEP_CSR, CSR_ENABLE_TEST, 32'h1, 3, 0);
        add_step(STEP_RESET, CSR_DSM_BASE, 32'h0, -1, 10);
        add_step(STEP_CSR, CSR_DSM_BASE, 32'h0000_3000, 0, 4);
        add_step(STEP_CSR, CSR_ENABLE_TEST, 32'h1, `QA_TEST_LINES, 4);
    endtask

    // ====================
    // Main sequence
    // ====================

    initial
    begin
        seed         = 32'h6673;
        resetb       = 1'b0;
        csr_wr_valid = 1'b0;
        csr_wr_addr  = CSR_DSM_BASE;
        csr_wr_data  = '0;
        cur_base     = '0;
        timeouts     = 0;
        build_table();
        repeat (3) @(posedge clk);
        @(negedge clk);
        resetb = 1'b1;
        for (i = 0; i < steps.size(); i++)
        begin
            run_step(steps[i]);
        end
        repeat (5) @(negedge clk);
        sva_fails = qa_driver_top_inst.qa_driver_sva_inst.assert_errors;
        $display("Checks: %0d, errors: %0d, assertion failures: %0d, timeouts: %0d",
                 check_count, error_count, sva_fails, timeouts);
        if (error_count == 0 && sva_fails == 0 && timeouts == 0 && check_count > 0)
        begin
            $display("Test OK");
        end
        else
        begin
            $display("Test FAILED");
        end
        $finish;
    end

endmodule

// File: sources.f
+incdir+design
design/qa_csr_pkg.sv
design/qa_ctrl_pkg.sv
design/qa_csr.sv
design/qa_status_writer.sv
design/qa_test_writer.sv
design/qa_write_arb.sv
design/qa_driver_top.sv
test/qa_driver_sva.sv
test/qa_driver_checker.sv
test/qa_driver_tb.sv
